//--- all.f
+incdir+design
design/dcache_pkg.sv
design/mem_pkg.sv
design/dcache_sram.sv
design/dcache_req_queue.sv
design/dcache_line_merge.sv
design/dcache_ctrl.sv
design/dcache_top.sv
verif/tb_mem_model.sv
verif/dcache_tb.sv

//--- design/dcache_ctrl.sv
`default_nettype none
`timescale 1ns/10ps

`include "dcache_defines.svh"

module dcache_ctrl
    import dcache_pkg::*;
    import mem_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  rst,

    // Request queue head
    input  wire logic                  q_valid_i,
    input  wire logic                  q_write_i,
    input  wire logic [`DC_ADDR_W-1:0] q_addr_i,
    output logic                       q_pop_o,

    // Metadata RAM
    output logic                       meta_rd_en_o,
    output dc_index_t                  meta_rd_addr_o,
    input  wire dc_meta_t              meta_rd_i,
    output logic                       meta_wr_en_o,
    output dc_index_t                  meta_wr_addr_o,
    output dc_meta_t                   meta_wr_o,

    // Data RAM
    output logic                       data_rd_en_o,
    output dc_index_t                  data_rd_addr_o,
    output logic                       data_wr_en_o,
    output dc_index_t                  data_wr_addr_o,
    output logic                       fill_sel_o,       // Write refill line, not RAM line

    output logic                       rsp_valid_o,

    // Memory port
    output logic                       mem_req_valid_o,
    output mem_cmd_e                   mem_req_cmd_o,
    output logic [`DC_ADDR_W-1:0]      mem_req_addr_o,
    input  wire logic                  mem_credit_i,
    input  wire logic                  mem_rsp_valid_i
);

    localparam int CW = $clog2(`DC_MEM_CREDITS + 1);

    dc_state_e             state_q, state_d;
    dc_index_t             init_idx_q;     // Sweep pointer
    logic [CW-1:0]         credits_q;
    logic [`DC_ADDR_W-1:0] req_addr_q;     // Popped request
    logic                  req_write_q;

    dc_tag_t   req_tag;
    dc_index_t req_idx;
    logic      hit;
    logic      has_credit;

    assign req_tag    = req_addr_q[`DC_ADDR_W-1 -: `DC_TAG_W];
    assign req_idx    = req_addr_q[`DC_OFFSET_W +: `DC_INDEX_W];
    assign hit        = meta_rd_i.valid && (meta_rd_i.tag == req_tag);
    assign has_credit = (credits_q != '0);

    // Both RAMs read the queue head; written at the held request index
    assign meta_rd_addr_o = q_addr_i[`DC_OFFSET_W +: `DC_INDEX_W];
    assign data_rd_addr_o = q_addr_i[`DC_OFFSET_W +: `DC_INDEX_W];
    assign meta_wr_addr_o = (state_q == INIT) ? init_idx_q : req_idx;
    assign data_wr_addr_o = req_idx;

    always_comb begin
        state_d         = state_q;
        q_pop_o         = 1'b0;
        meta_rd_en_o    = 1'b0;
        data_rd_en_o    = 1'b0;
        meta_wr_en_o    = 1'b0;
        meta_wr_o       = '0;            // Sweep writes invalid entries
        data_wr_en_o    = 1'b0;
        fill_sel_o      = 1'b0;
        rsp_valid_o     = 1'b0;
        mem_req_valid_o = 1'b0;
        mem_req_cmd_o   = MEM_READ_LINE;
        mem_req_addr_o  = {req_addr_q[`DC_ADDR_W-1:`DC_OFFSET_W], {`DC_OFFSET_W{1'b0}}};
        case (state_q)
            INIT: begin
                meta_wr_en_o = 1'b1;
                if (init_idx_q == '1) state_d = IDLE;  // Last set cleared
            end
            IDLE: begin
                if (q_valid_i) state_d = LOOKUP;
            end
            LOOKUP: begin
                q_pop_o      = 1'b1;
                meta_rd_en_o = 1'b1;
                data_rd_en_o = 1'b1;
                state_d      = COMPARE;
            end
            COMPARE: begin
                if (hit) begin
                    rsp_valid_o = 1'b1;
                    if (req_write_q) begin
                        data_wr_en_o = 1'b1;              // Merged hit line
                        meta_wr_en_o = 1'b1;
                        meta_wr_o    = '{tag: req_tag, dirty: 1'b1, valid: 1'b1};
                    end
                    state_d = IDLE;
                end else if (meta_rd_i.valid && meta_rd_i.dirty) begin
                    state_d = WB_REQ;
                end else begin
                    state_d = FILL_REQ;
                end
            end
            WB_REQ: begin
                // Victim tag and line stay on the RAM outputs meanwhile
                mem_req_valid_o = has_credit;
                mem_req_cmd_o   = MEM_WRITE_LINE;
                mem_req_addr_o  = {meta_rd_i.tag, req_idx, {`DC_OFFSET_W{1'b0}}};
                if (has_credit) state_d = FILL_REQ;
            end
            FILL_REQ: begin
                mem_req_valid_o = has_credit;
                if (has_credit) state_d = FILL_WAIT;
            end
            FILL_WAIT: begin
                if (mem_rsp_valid_i) begin
                    data_wr_en_o = 1'b1;
                    fill_sel_o   = 1'b1;
                    meta_wr_en_o = 1'b1;
                    meta_wr_o    = '{tag: req_tag, dirty: req_write_q, valid: 1'b1};
                    state_d      = REPLAY;
                end
            end
            REPLAY: begin
                rsp_valid_o = 1'b1;  // Word was captured at the fill
                state_d     = IDLE;
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q     <= INIT;
            init_idx_q  <= '0;
            credits_q   <= CW'(`DC_MEM_CREDITS);
            req_write_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == INIT) init_idx_q <= init_idx_q + 1'b1;
            if (q_pop_o) req_write_q <= q_write_i;
            case ({mem_req_valid_o, mem_credit_i})
                2'b10:   credits_q <= credits_q - CW'(1);  // Spent
                2'b01:   credits_q <= credits_q + CW'(1);  // Returned
                default: credits_q <= credits_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (q_pop_o) req_addr_q <= q_addr_i;
    end

    // A returned credit with none spent must find room below the limit
    a_credit_bound: assert property (@(posedge clk) disable iff (rst)
        mem_credit_i && !mem_req_valid_o |-> credits_q != CW'(`DC_MEM_CREDITS))
        else $error("memory credit count above limit");
    a_rsp_in_fill_wait: assert property (@(posedge clk) disable iff (rst)
        mem_rsp_valid_i |-> state_q == FILL_WAIT)
        else $error("memory response outside refill wait");

endmodule

`default_nettype wire

//--- design/dcache_defines.svh
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// Address split, byte address = {tag, index, offset}
`define DC_ADDR_W      32
`define DC_OFFSET_W    4   // 16-byte lines
`define DC_INDEX_W     6   // 64 sets
`define DC_TAG_W       (`DC_ADDR_W - `DC_INDEX_W - `DC_OFFSET_W)

// 32-bit words per line
`define DC_LINE_WORDS  4

// Requester queue depth, also the requester's starting credits
`define DC_REQ_CREDITS 2

// Outstanding memory requests allowed
`define DC_MEM_CREDITS 1

`endif

//--- design/dcache_line_merge.sv
`default_nettype none
`timescale 1ns/10ps

`include "dcache_defines.svh"

module dcache_line_merge
    import dcache_pkg::*;
(
    input  wire dc_line_t              line_i,    // RAM line or refill line
    input  wire logic [`DC_ADDR_W-1:0] addr_i,    // Request byte address
    input  wire logic [31:0]           wdata_i,
    input  wire logic [3:0]            wmask_i,   // Zero for reads
    output dc_line_t                   line_o,
    output logic [31:0]                word_o
);

    localparam int WSEL_W = `DC_OFFSET_W - 2;

    logic [WSEL_W-1:0] wsel;  // Word within the line

    assign wsel = addr_i[`DC_OFFSET_W-1:2];

    // Read word comes from the unmerged line
    assign word_o = line_i[wsel*32 +: 32];

    always_comb begin
        line_o = line_i;  // Untouched words pass through
        for (int b = 0; b < 4; b++) begin
            if (wmask_i[b]) begin
                line_o[wsel*32 + b*8 +: 8] = wdata_i[b*8 +: 8];  // Masked byte
            end
        end
    end

endmodule

`default_nettype wire

//--- design/dcache_pkg.sv
`default_nettype none

`include "dcache_defines.svh"

package dcache_pkg;

    typedef logic [`DC_TAG_W-1:0]   dc_tag_t;
    typedef logic [`DC_INDEX_W-1:0] dc_index_t;

    // Whole line, word 0 in the low bits
    typedef logic [`DC_LINE_WORDS*32-1:0] dc_line_t;

    // One metadata entry per set
    typedef struct packed {
        dc_tag_t tag;
        logic    dirty;  // Line differs from memory
        logic    valid;
    } dc_meta_t;

    typedef enum logic [2:0] {
        INIT,       // Clearing valid bits after reset
        IDLE,
        LOOKUP,     // Pop and read both RAMs
        COMPARE,    // Tag check on RAM output
        WB_REQ,     // Dirty victim out to memory
        FILL_REQ,   // Line read request
        FILL_WAIT,  // Waiting for refill data
        REPLAY      // Answer the missed request
    } dc_state_e;

endpackage

`default_nettype wire

//--- design/dcache_req_queue.sv
`default_nettype none
`timescale 1ns/10ps

`include "dcache_defines.svh"

module dcache_req_queue (
    input  wire logic                  clk,
    input  wire logic                  rst,

    input  wire logic                  push_i,
    input  wire logic                  push_write_i,
    input  wire logic [`DC_ADDR_W-1:0] push_addr_i,
    input  wire logic [31:0]           push_wdata_i,
    input  wire logic [3:0]            push_wmask_i,

    input  wire logic                  pop_i,
    output logic                       valid_o,     // Head entry present
    output logic                       write_o,
    output logic [`DC_ADDR_W-1:0]      addr_o,
    output logic [31:0]                wdata_o,
    output logic [3:0]                 wmask_o,

    output logic                       credit_o     // One pulse per pop
);

    localparam int DEPTH = `DC_REQ_CREDITS;
    localparam int PW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW    = $clog2(DEPTH + 1);

    logic                  write_mem [DEPTH];
    logic [`DC_ADDR_W-1:0] addr_mem  [DEPTH];
    logic [31:0]           wdata_mem [DEPTH];
    logic [3:0]            wmask_mem [DEPTH];

    logic [PW-1:0] wr_ptr_q;
    logic [PW-1:0] rd_ptr_q;
    logic [CW-1:0] count_q;
    logic          full;

    assign full    = (count_q == CW'(DEPTH));
    assign valid_o = (count_q != '0);
    assign write_o = write_mem[rd_ptr_q];
    assign addr_o  = addr_mem[rd_ptr_q];
    assign wdata_o = wdata_mem[rd_ptr_q];
    assign wmask_o = wmask_mem[rd_ptr_q];

    // Payload storage
    always_ff @(posedge clk) begin
        if (push_i) begin
            write_mem[wr_ptr_q] <= push_write_i;
            addr_mem[wr_ptr_q]  <= push_addr_i;
            wdata_mem[wr_ptr_q] <= push_wdata_i;
            wmask_mem[wr_ptr_q] <= push_wmask_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            credit_o <= 1'b0;
        end else begin
            credit_o <= pop_i;  // Credit back one cycle after the pop
            if (push_i) begin
                wr_ptr_q <= (wr_ptr_q == PW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q <= (rd_ptr_q == PW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({push_i, pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;  // Both or neither
            endcase
        end
    end

    // Requester must honour credits
    a_no_push_full: assert property (@(posedge clk) disable iff (rst) push_i |-> !full)
        else $error("request queue push while full");
    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst) pop_i |-> valid_o)
        else $error("request queue pop while empty");

endmodule

`default_nettype wire

//--- design/dcache_sram.sv
`default_nettype none
`timescale 1ns/10ps

module dcache_sram
    import dcache_pkg::*;
#(
    parameter type entry_t = logic,
    parameter int  DEPTH   = 64
) (
    input  wire logic      clk,
    input  wire logic      rst,

    input  wire logic      rd_en_i,
    input  wire dc_index_t rd_addr_i,
    output entry_t         rd_data_o,   // Valid the cycle after rd_en_i

    input  wire logic      wr_en_i,
    input  wire dc_index_t wr_addr_i,
    input  wire entry_t    wr_data_i
);

    entry_t mem [DEPTH];  // Storage, contents undefined until written

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // Output register holds its value while no read is issued
    // Same-address write in the same cycle returns old contents
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_data_o <= '0;
        end else if (rd_en_i) begin
            rd_data_o <= mem[rd_addr_i];
        end
    end

endmodule

`default_nettype wire

//--- design/dcache_top.sv
`default_nettype none
`timescale 1ns/10ps

`include "dcache_defines.svh"

module dcache_top
    import dcache_pkg::*;
    import mem_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  rst,

    // Requester
    input  wire logic                  req_valid_i,
    input  wire logic                  req_write_i,
    input  wire logic [`DC_ADDR_W-1:0] req_addr_i,
    input  wire logic [31:0]           req_wdata_i,
    input  wire logic [3:0]            req_wmask_i,
    output logic                       req_credit_o,
    output logic                       rsp_valid_o,
    output logic [31:0]                rsp_rdata_o,

    // Memory
    output logic                       mem_req_valid_o,
    output mem_cmd_e                   mem_req_cmd_o,
    output logic [`DC_ADDR_W-1:0]      mem_req_addr_o,
    output mem_line_t                  mem_req_line_o,
    input  wire logic                  mem_credit_i,
    input  wire logic                  mem_rsp_valid_i,
    input  wire mem_line_t             mem_rsp_line_i
);

    logic                  q_valid, q_write, q_pop;
    logic [`DC_ADDR_W-1:0] q_addr;
    logic [31:0]           q_wdata;
    logic [3:0]            q_wmask;

    logic      meta_rd_en, meta_wr_en, data_rd_en, data_wr_en, fill_sel;
    dc_index_t meta_rd_addr, meta_wr_addr, data_rd_addr, data_wr_addr;
    dc_meta_t  meta_rd, meta_wr;
    dc_line_t  data_rd_line, merge_in, merge_out;
    logic [31:0] merge_word;

    // Pending request payload, captured at pop
    logic [`DC_ADDR_W-1:0] pend_addr_q;
    logic [31:0]           pend_wdata_q;
    logic [3:0]            pend_wmask_q;   // Zero for reads so a refill stays clean
    logic [31:0]           fill_word_q;    // Read word from the refill line
    logic                  replay_q;       // Cycle after a refill write

    always_ff @(posedge clk) begin
        if (q_pop) begin
            pend_addr_q  <= q_addr;
            pend_wdata_q <= q_wdata;
            pend_wmask_q <= q_write ? q_wmask : 4'h0;
        end
        if (data_wr_en && fill_sel) fill_word_q <= merge_word;
    end

    always_ff @(posedge clk) begin
        if (rst) replay_q <= 1'b0;
        else     replay_q <= data_wr_en && fill_sel;
    end

    assign merge_in       = fill_sel ? dc_line_t'(mem_rsp_line_i) : data_rd_line;
    assign rsp_rdata_o    = replay_q ? fill_word_q : merge_word;
    assign mem_req_line_o = mem_line_t'(data_rd_line);  // Victim line for writeback

    dcache_req_queue i_queue (
        .clk, .rst,
        .push_i(req_valid_i), .push_write_i(req_write_i), .push_addr_i(req_addr_i),
        .push_wdata_i(req_wdata_i), .push_wmask_i(req_wmask_i),
        .pop_i(q_pop), .valid_o(q_valid), .write_o(q_write), .addr_o(q_addr),
        .wdata_o(q_wdata), .wmask_o(q_wmask), .credit_o(req_credit_o)
    );

    dcache_sram #(.entry_t(dc_meta_t), .DEPTH(1 << `DC_INDEX_W)) i_meta_ram (
        .clk, .rst,
        .rd_en_i(meta_rd_en), .rd_addr_i(meta_rd_addr), .rd_data_o(meta_rd),
        .wr_en_i(meta_wr_en), .wr_addr_i(meta_wr_addr), .wr_data_i(meta_wr)
    );

    dcache_sram #(.entry_t(dc_line_t), .DEPTH(1 << `DC_INDEX_W)) i_data_ram (
        .clk, .rst,
        .rd_en_i(data_rd_en), .rd_addr_i(data_rd_addr), .rd_data_o(data_rd_line),
        .wr_en_i(data_wr_en), .wr_addr_i(data_wr_addr), .wr_data_i(merge_out)
    );

    dcache_line_merge i_merge (
        .line_i(merge_in), .addr_i(pend_addr_q), .wdata_i(pend_wdata_q),
        .wmask_i(pend_wmask_q), .line_o(merge_out), .word_o(merge_word)
    );

    dcache_ctrl i_ctrl (
        .clk, .rst,
        .q_valid_i(q_valid), .q_write_i(q_write), .q_addr_i(q_addr), .q_pop_o(q_pop),
        .meta_rd_en_o(meta_rd_en), .meta_rd_addr_o(meta_rd_addr), .meta_rd_i(meta_rd),
        .meta_wr_en_o(meta_wr_en), .meta_wr_addr_o(meta_wr_addr), .meta_wr_o(meta_wr),
        .data_rd_en_o(data_rd_en), .data_rd_addr_o(data_rd_addr),
        .data_wr_en_o(data_wr_en), .data_wr_addr_o(data_wr_addr), .fill_sel_o(fill_sel),
        .rsp_valid_o,
        .mem_req_valid_o, .mem_req_cmd_o, .mem_req_addr_o,
        .mem_credit_i, .mem_rsp_valid_i
    );

endmodule

`default_nettype wire

//--- design/mem_pkg.sv
`default_nettype none

`include "dcache_defines.svh"

package mem_pkg;

    // Single command bit on the memory port
    typedef enum logic {
        MEM_READ_LINE  = 1'b0,
        MEM_WRITE_LINE = 1'b1  // Writeback, answered by credit only
    } mem_cmd_e;

    // Line as memory sees it, word 0 low
    typedef logic [`DC_LINE_WORDS*32-1:0] mem_line_t;

endpackage

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# Build and run the data cache testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module dcache_tb -f all.f \
    -Mdir obj_dir -o dcache_sim > build.log 2>&1 \
    && ./obj_dir/dcache_sim > "$LOG" 2>&1 \
    || { echo "Build or simulation did not complete, see build.log and $LOG"; exit 1; }

cat "$LOG"

grep -q "Regression failed" "$LOG" && exit 1
grep -q "Regression passed" "$LOG" || exit 1
exit 0

//--- verif/dcache_tb.sv
`default_nettype none
`timescale 1ns/10ps

`include "dcache_defines.svh"

module dcache_tb
    import mem_pkg::*;
();

    localparam int  MAX_VEC = 40;
    localparam int  FIELDS  = 7;          // op addr wdata mask expect check nmem
    localparam int  LIMIT   = 64 + MAX_VEC * 40;
    localparam int  REQ_CR  = `DC_REQ_CREDITS;
    localparam int  MEM_CR  = `DC_MEM_CREDITS;

    logic        clk, rst;
    logic        req_valid, req_write, req_credit, rsp_valid;
    logic [31:0] req_addr, req_wdata, rsp_rdata;
    logic [3:0]  req_wmask;
    logic        mem_req_valid, mem_credit, mem_rsp_valid;
    mem_cmd_e    mem_req_cmd;
    logic [31:0] mem_req_addr;
    mem_line_t   mem_req_line, mem_rsp_line;

    logic [31:0] vec_mem [MAX_VEC*FIELDS + FIELDS];
    logic [31:0] exp_q [$];               // Expected read words in issue order
    logic [31:0] shadow [logic [31:0]];   // Words written by completed stores
    mem_cmd_e    log_cmd [4];             // Memory traffic of the current request
    logic [31:0] log_addr [4];
    int nvec, issued, credit_cnt, rsp_cnt, cycle_cnt, mem_owed, log_n;
    int err_cnt, err_mark, main_err, tests_pass, tests_fail;

    dcache_top i_dut (
        .clk, .rst,
        .req_valid_i(req_valid), .req_write_i(req_write), .req_addr_i(req_addr),
        .req_wdata_i(req_wdata), .req_wmask_i(req_wmask), .req_credit_o(req_credit),
        .rsp_valid_o(rsp_valid), .rsp_rdata_o(rsp_rdata),
        .mem_req_valid_o(mem_req_valid), .mem_req_cmd_o(mem_req_cmd),
        .mem_req_addr_o(mem_req_addr), .mem_req_line_o(mem_req_line),
        .mem_credit_i(mem_credit), .mem_rsp_valid_i(mem_rsp_valid),
        .mem_rsp_line_i(mem_rsp_line)
    );

    tb_mem_model i_mem (
        .clk, .rst,
        .req_valid_i(mem_req_valid), .req_cmd_i(mem_req_cmd), .req_addr_i(mem_req_addr),
        .req_line_i(mem_req_line), .credit_o(mem_credit), .rsp_valid_o(mem_rsp_valid),
        .rsp_line_o(mem_rsp_line)
    );

    // Expected memory word from the initial rule and finished stores
    function automatic logic [31:0] shadow_word(input logic [31:0] a);
        if (shadow.exists(a)) return shadow[a];
        return a ^ 32'hc0de0000;
    endfunction

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        int b;
        rst       = 1'b1;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        req_wmask = '0;
        issued    = 0;
        main_err  = 0;
        void'($urandom(32'h4ef2c21e));
        $readmemh("verif/dcache_vectors.txt", vec_mem);
        nvec = 0;
        while (nvec < MAX_VEC && vec_mem[nvec*FIELDS] != 32'hf) nvec++;  // f marks the end
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        if (rsp_valid || mem_req_valid || req_credit) begin
            $display("reset: outputs not low after reset");
            main_err++;
        end else begin
            $display("test reset: passed");
        end
        while (issued < nvec && cycle_cnt < LIMIT) begin
            @(posedge clk);
            req_valid <= 1'b0;
            if (issued - credit_cnt < REQ_CR) begin  // Holding a credit
                b = issued * FIELDS;
                req_valid <= 1'b1;
                req_write <= vec_mem[b][0];
                req_addr  <= vec_mem[b+1];
                req_wdata <= vec_mem[b+2];
                req_wmask <= vec_mem[b+3][3:0];
                exp_q.push_back(vec_mem[b+4]);
                issued++;
            end
        end
        @(posedge clk);
        req_valid <= 1'b0;
        while (rsp_cnt < nvec && cycle_cnt < LIMIT) @(negedge clk);
        if (rsp_cnt < nvec) begin
            $display("timeout: %0d of %0d responses after %0d cycles", rsp_cnt, nvec, cycle_cnt);
            main_err++;
        end
        repeat (4) @(negedge clk);  // Catch stray responses
        if (credit_cnt != issued) begin
            $display("credits: %0d returned for %0d requests", credit_cnt, issued);
            main_err++;
        end
        $display("summary: %0d tests passed, %0d failed, %0d errors",
                 tests_pass, tests_fail, err_cnt + main_err);
        if (err_cnt == 0 && main_err == 0 && tests_fail == 0 && nvec > 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // Monitor, all DUT outputs sampled mid-cycle
    always @(negedge clk) begin
        int base;
        logic [31:0] line_base;
        logic [31:0] exp_word;
        logic [31:0] w;
        if (!rst) begin
            cycle_cnt++;
            if (req_credit) begin
                credit_cnt++;
                if (credit_cnt > issued) begin
                    $display("credit: req_credit_o with no request outstanding at %0t", $time);
                    err_cnt++;
                end
            end
            // Queue entries plus the one request in service
            if (issued - rsp_cnt > REQ_CR + 1) begin
                $display("credit: cache holds more than %0d requests at %0t",
                         REQ_CR + 1, $time);
                err_cnt++;
            end
            if (mem_req_valid && mem_owed >= MEM_CR) begin
                $display("memory: request at %0t while memory still owes its credit", $time);
                err_cnt++;
            end
            if (mem_req_valid) mem_owed++;
            if (mem_credit) mem_owed--;
            if (mem_req_valid) begin
                if (log_n < 4) begin
                    log_cmd[log_n]  = mem_req_cmd;
                    log_addr[log_n] = mem_req_addr;
                end
                log_n++;
                if (mem_req_cmd == MEM_WRITE_LINE) begin
                    for (int i = 0; i < 4; i++) begin
                        w = shadow_word(mem_req_addr + 32'(i * 4));
                        if (mem_req_line[i*32 +: 32] != w) begin
                            $display("mismatch at %0t: mem_req_line_o word %0d expected %h actual %h",
                                     $time, i, w, mem_req_line[i*32 +: 32]);
                            err_cnt++;
                        end
                    end
                end
            end
            if (rsp_valid) begin
                if (exp_q.size() == 0) begin
                    $display("response: rsp_valid_o at %0t with no request outstanding", $time);
                    err_cnt++;
                end else begin
                    exp_word  = exp_q.pop_front();
                    base      = rsp_cnt * FIELDS;
                    line_base = {vec_mem[base+1][31:4], 4'h0};
                    if (vec_mem[base] == 0 && vec_mem[base+5] != 0 && rsp_rdata != exp_word) begin
                        $display("mismatch at %0t: rsp_rdata_o expected %h actual %h",
                                 $time, exp_word, rsp_rdata);
                        err_cnt++;
                    end
                    if (log_n != int'(vec_mem[base+6])) begin
                        $display("memory: request %0d caused %0d memory requests, expected %0d",
                                 rsp_cnt, log_n, vec_mem[base+6]);
                        err_cnt++;
                    end else if (log_n > 0) begin
                        if (log_cmd[log_n-1] != MEM_READ_LINE
                                || log_addr[log_n-1] != line_base) begin
                            $display("memory: refill for request %0d not a line read at %h",
                                     rsp_cnt, line_base);
                            err_cnt++;
                        end
                        if (log_n == 2 && (log_cmd[0] != MEM_WRITE_LINE
                                || log_addr[0][9:4] != line_base[9:4]
                                || log_addr[0] == line_base)) begin
                            $display("memory: request %0d missing writeback of the victim line",
                                     rsp_cnt);
                            err_cnt++;
                        end
                    end
                    if (vec_mem[base] == 1) begin  // Store takes effect at its response
                        w = shadow_word({vec_mem[base+1][31:2], 2'b00});
                        for (int i = 0; i < 4; i++) begin
                            if (vec_mem[base+3][i]) w[i*8 +: 8] = vec_mem[base+2][i*8 +: 8];
                        end
                        shadow[{vec_mem[base+1][31:2], 2'b00}] = w;
                    end
                    if (err_cnt == err_mark) begin
                        tests_pass++;
                        $display("test %0d addr %h: passed", rsp_cnt, vec_mem[base+1]);
                    end else begin
                        tests_fail++;
                        $display("test %0d addr %h: FAILED", rsp_cnt, vec_mem[base+1]);
                    end
                    rsp_cnt++;
                    log_n    = 0;
                    err_mark = err_cnt;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- verif/dcache_vectors.txt
// op(0 read, 1 write) addr wdata mask expected_rdata check_rdata mem_requests
// One request per line, a line starting with f ends the list
0 00001040 00000000 0 c0de1040 1 1
0 00001044 00000000 0 c0de1044 1 0
0 0000104c 00000000 0 c0de104c 1 0
1 00001048 11223344 5 00000000 0 0
0 00001048 00000000 0 c0221044 1 0
// Same set, new tag, dirty victim
0 00001448 00000000 0 c0de1448 1 2
0 00001048 00000000 0 c0221044 1 1
// Write miss allocates
1 00002084 deadbeef f 00000000 0 1
0 00002084 00000000 0 deadbeef 1 0
0 00002080 00000000 0 c0de2080 1 0
1 00002088 a5a5a5a5 8 00000000 0 0
0 00002488 00000000 0 c0de2488 1 2
0 00002084 00000000 0 deadbeef 1 1
0 00002088 00000000 0 a5de2088 1 0
// Two partial stores to one word
1 000030f0 0000abcd 3 00000000 0 1
1 000030f0 99000000 8 00000000 0 0
0 000034f0 00000000 0 c0de34f0 1 2
0 000030f0 00000000 0 99deabcd 1 1
// Last set and set zero
0 00fff3fc 00000000 0 c021f3fc 1 1
0 00fff3f0 00000000 0 c021f3f0 1 0
0 00000000 00000000 0 c0de0000 1 1
1 0000000c 12345678 6 00000000 0 0
0 0000000c 00000000 0 c034560c 1 0
0 00001040 00000000 0 c0de1040 1 0
f 00000000 00000000 0 00000000 0 0

//--- verif/tb_mem_model.sv
`default_nettype none
`timescale 1ns/10ps

module tb_mem_model
    import mem_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        req_valid_i,
    input  wire mem_cmd_e    req_cmd_i,
    input  wire logic [31:0] req_addr_i,    // Line aligned
    input  wire mem_line_t   req_line_i,
    output logic             credit_o,
    output logic             rsp_valid_o,
    output mem_line_t        rsp_line_o
);

    logic [31:0] words [logic [31:0]];  // Only words written back so far
    logic        busy_q;
    logic [3:0]  wait_q;                // Cycles left before the answer
    logic [31:0] addr_q;
    logic        read_q;

    // Unwritten words follow the address rule
    function automatic logic [31:0] word_at(input logic [31:0] a);
        if (words.exists(a)) return words[a];
        return a ^ 32'hc0de0000;
    endfunction

    function automatic mem_line_t line_at(input logic [31:0] base);
        mem_line_t l;
        for (int w = 0; w < 4; w++) begin
            l[w*32 +: 32] = word_at(base + 32'(w * 4));
        end
        return l;
    endfunction

    always @(posedge clk) begin
        credit_o    <= 1'b0;
        rsp_valid_o <= 1'b0;
        if (rst) begin
            busy_q     <= 1'b0;
            wait_q     <= '0;
            rsp_line_o <= '0;
        end else begin
            if (busy_q) begin
                if (wait_q == 4'd1) begin
                    credit_o    <= 1'b1;     // Credit with the data for reads
                    rsp_valid_o <= read_q;   // Writebacks get credit only
                    rsp_line_o  <= line_at(addr_q);
                    busy_q      <= 1'b0;
                end
                wait_q <= wait_q - 4'd1;
            end
            if (req_valid_i) begin
                busy_q <= 1'b1;
                wait_q <= 4'(1 + ($urandom % 8));  // 1 to 8 cycles
                addr_q <= req_addr_i;
                read_q <= (req_cmd_i == MEM_READ_LINE);
                if (req_cmd_i == MEM_WRITE_LINE) begin
                    for (int w = 0; w < 4; w++) begin
                        words[req_addr_i + 32'(w * 4)] = req_line_i[w*32 +: 32];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire
